/* hw/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
  input  rv_isa_pkg::word_t      pc,
  input  rv_isa_pkg::word_t      rs1_data,
  input  rv_isa_pkg::word_t      rs2_data,
  input  rv_isa_pkg::word_t      imm,
  input  rv_core_pkg::alu_op_e   alu_op,
  input  rv_core_pkg::a_sel_e    a_sel,
  input  rv_core_pkg::b_sel_e    b_sel,
  input  rv_isa_pkg::branch_f3_e branch_cond,
  output rv_isa_pkg::word_t      alu_result,
  output logic                   branch_taken
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  word_t      op_a;
  word_t      op_b;
  word_t      sum;
  logic [4:0] shamt;
  logic       link;
  logic       eq;
  logic       lt;
  logic       ltu;

  always_comb begin
    case (a_sel)
      A_PC:    op_a = pc;
      A_ZERO:  op_a = '0;
      default: op_a = rs1_data;
    endcase
  end

  // PASS_B on top of pc is a jump, B becomes the fixed step 4
  assign link  = (alu_op == PASS_B) && (a_sel == A_PC);
  assign op_b  = link ? word_t'(4) : ((b_sel == B_IMM) ? imm : rs2_data);
  assign sum   = op_a + op_b;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      SUB:     alu_result = op_a - op_b;
      SLL:     alu_result = op_a << shamt;
      SLT:     alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      SLTU:    alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
      XOR:     alu_result = op_a ^ op_b;
      SRL:     alu_result = op_a >> shamt;
      SRA:     alu_result = $signed(op_a) >>> shamt;
      OR:      alu_result = op_a | op_b;
      AND:     alu_result = op_a & op_b;
      PASS_B:  alu_result = link ? sum : op_b;
      default: alu_result = sum;
    endcase
  end

  // Branch compare always uses the two register operands
  assign eq  = (rs1_data == rs2_data);
  assign lt  = $signed(rs1_data) < $signed(rs2_data);
  assign ltu = rs1_data < rs2_data;

  always_comb begin
    case (branch_cond)
      BR_EQ:   branch_taken = eq;
      BR_NE:   branch_taken = !eq;
      BR_LT:   branch_taken = lt;
      BR_GE:   branch_taken = !lt;
      BR_LTU:  branch_taken = ltu;
      BR_GEU:  branch_taken = !ltu;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

/* hw/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
  parameter rv_isa_pkg::word_t RESET_PC = '0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_isa_pkg::word_t    insn_from_imem,
  input  rv_isa_pkg::word_t    load_data_from_dmem,
  output rv_isa_pkg::word_t    pc_to_imem,
  output rv_isa_pkg::word_t    addr_to_dmem,
  output rv_isa_pkg::word_t    store_data_to_dmem,
  output rv_isa_pkg::byte_en_t store_we_to_dmem,
  output logic                 halt
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  phase_e     phase;
  logic       rf_we;
  reg_addr_t  rs1_addr;
  reg_addr_t  rs2_addr;
  reg_addr_t  rd_addr;
  word_t      imm;
  alu_op_e    alu_op;
  a_sel_e     a_sel;
  b_sel_e     b_sel;
  pc_sel_e    pc_sel;
  branch_f3_e branch_cond;
  mem_f3_e    mem_size;
  logic       is_load;
  logic       is_store;
  logic       reg_write;
  logic       is_ecall;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_result;
  logic       branch_taken;
  word_t      rd_data;

  rv_fetch_ctrl #(
    .RESET_PC(RESET_PC)
  ) fetch_ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .pc_sel      (pc_sel),
    .branch_taken(branch_taken),
    .is_load     (is_load),
    .reg_write   (reg_write),
    .is_ecall    (is_ecall),
    .imm         (imm),
    .rs1_data    (rs1_data),
    .pc          (pc_to_imem),
    .phase       (phase),
    .rf_we       (rf_we),
    .halt        (halt)
  );

  rv_decode decode_i (
    .insn       (insn_from_imem),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rd_addr    (rd_addr),
    .imm        (imm),
    .alu_op     (alu_op),
    .a_sel      (a_sel),
    .b_sel      (b_sel),
    .pc_sel     (pc_sel),
    .branch_cond(branch_cond),
    .mem_size   (mem_size),
    .is_load    (is_load),
    .is_store   (is_store),
    .reg_write  (reg_write),
    .is_ecall   (is_ecall)
  );

  rv_regfile regfile_i (
    .clk     (clk),
    .rst     (rst),
    .we      (rf_we),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  rv_alu alu_i (
    .pc          (pc_to_imem),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .alu_op      (alu_op),
    .a_sel       (a_sel),
    .b_sel       (b_sel),
    .branch_cond (branch_cond),
    .alu_result  (alu_result),
    .branch_taken(branch_taken)
  );

  rv_lsu lsu_i (
    .phase              (phase),
    .is_load            (is_load),
    .is_store           (is_store),
    .mem_size           (mem_size),
    .alu_result         (alu_result),
    .rs2_data           (rs2_data),
    .load_data_from_dmem(load_data_from_dmem),
    .addr_to_dmem       (addr_to_dmem),
    .store_data_to_dmem (store_data_to_dmem),
    .rd_data            (rd_data),
    .store_we_to_dmem   (store_we_to_dmem)
  );

endmodule

/* hw/rv_core_pkg.sv */
package rv_core_pkg;

  // Sequencer phases, one instruction at a time
  typedef enum logic [1:0] {
    PH_FETCH = 2'd0,
    PH_EXEC  = 2'd1,
    PH_LOAD  = 2'd2,
    PH_HALT  = 2'd3
  } phase_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS_B
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {
    A_RS1,
    A_PC,
    A_ZERO
  } a_sel_e;

  // Operand B source
  typedef enum logic {
    B_RS2,
    B_IMM
  } b_sel_e;

  typedef enum logic [1:0] {
    PC_PLUS4,
    PC_BRANCH,
    PC_JAL,
    PC_JALR
  } pc_sel_e;

endpackage

/* hw/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode (
  input  rv_isa_pkg::word_t        insn,
  output rv_isa_pkg::reg_addr_t    rs1_addr,
  output rv_isa_pkg::reg_addr_t    rs2_addr,
  output rv_isa_pkg::reg_addr_t    rd_addr,
  output rv_isa_pkg::word_t        imm,
  output rv_core_pkg::alu_op_e     alu_op,
  output rv_core_pkg::a_sel_e      a_sel,
  output rv_core_pkg::b_sel_e      b_sel,
  output rv_core_pkg::pc_sel_e     pc_sel,
  output rv_isa_pkg::branch_f3_e   branch_cond,
  output rv_isa_pkg::mem_f3_e      mem_size,
  output logic                     is_load,
  output logic                     is_store,
  output logic                     reg_write,
  output logic                     is_ecall
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  localparam logic [6:0] F7_ALT = 7'b010_0000;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  logic       writes;

  // ALU operation for funct3 when funct7 selects the base form
  function automatic alu_op_e base_op(logic [2:0] f3);
    case (f3)
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b101:  return SRL;
      3'b110:  return OR;
      3'b111:  return AND;
      default: return ADD;
    endcase
  endfunction

  assign opcode   = opcode_e'(insn[6:0]);
  assign rd_addr  = insn[11:7];
  assign funct3   = insn[14:12];
  assign rs1_addr = insn[19:15];
  assign rs2_addr = insn[24:20];
  assign funct7   = insn[31:25];

  // Sign-extended immediates of each format
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign branch_cond = branch_f3_e'(funct3);
  assign mem_size    = mem_f3_e'(funct3);
  assign is_ecall    = (insn == 32'h0000_0073);

  always_comb begin
    imm      = imm_i;
    alu_op   = ADD;
    a_sel    = A_RS1;
    b_sel    = B_IMM;
    pc_sel   = PC_PLUS4;
    is_load  = 1'b0;
    is_store = 1'b0;
    writes   = 1'b0;
    case (opcode)
      OP_LUI: begin
        imm = imm_u;
        alu_op = PASS_B;
        a_sel = A_ZERO;
        writes = 1'b1;
      end
      OP_AUIPC: begin
        imm = imm_u;
        a_sel = A_PC;
        writes = 1'b1;
      end
      // Jumps write the link address pc + 4
      OP_JAL: begin
        imm = imm_j;
        alu_op = PASS_B;
        a_sel = A_PC;
        pc_sel = PC_JAL;
        writes = 1'b1;
      end
      OP_JALR: begin
        if (funct3 == 3'b000) begin
          alu_op = PASS_B;
          a_sel = A_PC;
          pc_sel = PC_JALR;
          writes = 1'b1;
        end
      end
      OP_BRANCH: begin
        imm = imm_b;
        b_sel = B_RS2;
        // funct3 010 and 011 are not branches
        if (funct3[2:1] != 2'b01) begin
          pc_sel = PC_BRANCH;
        end
      end
      OP_LOAD: begin
        if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
          is_load = 1'b1;
          writes = 1'b1;
        end
      end
      OP_STORE: begin
        imm = imm_s;
        is_store = !funct3[2] && funct3[1:0] != 2'b11;
      end
      OP_REG_IMM: begin
        alu_op = base_op(funct3);
        if (funct3 == 3'b001) begin
          writes = (funct7 == 7'd0);
        end else if (funct3 == 3'b101) begin
          if (funct7 == F7_ALT) begin
            alu_op = SRA;
          end
          writes = (funct7 == 7'd0) || (funct7 == F7_ALT);
        end else begin
          writes = 1'b1;
        end
      end
      OP_REG_REG: begin
        b_sel = B_RS2;
        alu_op = base_op(funct3);
        if (funct7 == 7'd0) begin
          writes = 1'b1;
        end else if (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)) begin
          alu_op = (funct3 == 3'b000) ? SUB : SRA;
          writes = 1'b1;
        end
      end
      // FENCE and ECALL change no register or memory state here
      default: begin
        writes = 1'b0;
      end
    endcase
  end

  assign reg_write = writes && (rd_addr != '0);

endmodule

/* hw/rv_fetch_ctrl.sv */
`timescale 1ns/1ps

module rv_fetch_ctrl #(
  parameter rv_isa_pkg::word_t RESET_PC = '0
) (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_core_pkg::pc_sel_e   pc_sel,
  input  logic                   branch_taken,
  input  logic                   is_load,
  input  logic                   reg_write,
  input  logic                   is_ecall,
  input  rv_isa_pkg::word_t      imm,
  input  rv_isa_pkg::word_t      rs1_data,
  output rv_isa_pkg::word_t      pc,
  output rv_core_pkg::phase_e    phase,
  output logic                   rf_we,
  output logic                   halt
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  word_t  pc_plus4;
  word_t  pc_next;
  phase_e phase_next;

  assign pc_plus4 = pc + word_t'(4);

  always_comb begin
    case (pc_sel)
      PC_BRANCH: pc_next = branch_taken ? pc + imm : pc_plus4;
      PC_JAL:    pc_next = pc + imm;
      // Target of JALR has bit 0 cleared
      PC_JALR:   pc_next = (rs1_data + imm) & ~word_t'(1);
      default:   pc_next = pc_plus4;
    endcase
  end

  always_comb begin
    case (phase)
      PH_FETCH: phase_next = PH_EXEC;
      PH_EXEC: begin
        if (is_ecall) begin
          phase_next = PH_HALT;
        end else if (is_load) begin
          phase_next = PH_LOAD;
        end else begin
          phase_next = PH_FETCH;
        end
      end
      PH_LOAD: phase_next = PH_FETCH;
      default: phase_next = PH_HALT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= PH_FETCH;
      pc <= RESET_PC;
    end else begin
      phase <= phase_next;
      // PC stays on the ECALL once halted
      if (phase == PH_EXEC && !is_ecall) begin
        pc <= pc_next;
      end
    end
  end

  // Loads write back one phase later, once the data word is back
  assign rf_we = reg_write && ((phase == PH_EXEC && !is_load) || phase == PH_LOAD);
  assign halt = (phase == PH_HALT);

endmodule

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

  // Register and address width of RV32I
  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // One enable bit per byte lane of a word
  typedef logic [XLEN/8-1:0] byte_en_t;

  // Major opcodes, insn[6:0]
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b000_0011,
    OP_MISC_MEM = 7'b000_1111,
    OP_REG_IMM  = 7'b001_0011,
    OP_AUIPC    = 7'b001_0111,
    OP_STORE    = 7'b010_0011,
    OP_REG_REG  = 7'b011_0011,
    OP_LUI      = 7'b011_0111,
    OP_BRANCH   = 7'b110_0011,
    OP_JALR     = 7'b110_0111,
    OP_JAL      = 7'b110_1111,
    OP_SYSTEM   = 7'b111_0011
  } opcode_e;

  // Branch conditions, funct3 of OP_BRANCH
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_f3_e;

  // Access size and extension, funct3 of loads and stores
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101
  } mem_f3_e;

endpackage

/* hw/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu (
  input  rv_core_pkg::phase_e    phase,
  input  logic                   is_load,
  input  logic                   is_store,
  input  rv_isa_pkg::mem_f3_e    mem_size,
  input  rv_isa_pkg::word_t      alu_result,
  input  rv_isa_pkg::word_t      rs2_data,
  input  rv_isa_pkg::word_t      load_data_from_dmem,
  output rv_isa_pkg::word_t      addr_to_dmem,
  output rv_isa_pkg::word_t      store_data_to_dmem,
  output rv_isa_pkg::word_t      rd_data,
  output rv_isa_pkg::byte_en_t   store_we_to_dmem
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic [1:0] offset;
  logic       mem_active;
  word_t      load_shifted;
  word_t      load_value;

  assign offset = alu_result[1:0];

  // Address held through PH_LOAD, zero when no access is in flight
  assign mem_active = (phase == PH_EXEC || phase == PH_LOAD) && (is_load || is_store);
  assign addr_to_dmem = mem_active ? {alu_result[XLEN-1:2], 2'b00} : '0;

  // Store data moved up into its byte lanes
  assign store_data_to_dmem = rs2_data << {offset, 3'b000};

  always_comb begin
    store_we_to_dmem = '0;
    if (phase == PH_EXEC && is_store) begin
      case (mem_size)
        MEM_B:   store_we_to_dmem = byte_en_t'(1) << offset;
        MEM_H:   store_we_to_dmem = offset[1] ? 4'b1100 : 4'b0011;
        default: store_we_to_dmem = 4'b1111;
      endcase
    end
  end

  // Selected byte or half lands in the low bits
  assign load_shifted = load_data_from_dmem >> {offset, 3'b000};

  always_comb begin
    case (mem_size)
      MEM_B:   load_value = {{24{load_shifted[7]}}, load_shifted[7:0]};
      MEM_BU:  load_value = {24'b0, load_shifted[7:0]};
      MEM_H:   load_value = {{16{load_shifted[15]}}, load_shifted[15:0]};
      MEM_HU:  load_value = {16'b0, load_shifted[15:0]};
      default: load_value = load_data_from_dmem;
    endcase
  end

  // Writeback source
  assign rd_data = (phase == PH_LOAD) ? load_value : alu_result;

endmodule

/* hw/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  we,
  input  rv_isa_pkg::reg_addr_t rs1_addr,
  input  rv_isa_pkg::reg_addr_t rs2_addr,
  input  rv_isa_pkg::reg_addr_t rd_addr,
  input  rv_isa_pkg::word_t     rd_data,
  output rv_isa_pkg::word_t     rs1_data,
  output rv_isa_pkg::word_t     rs2_data
);
  import rv_isa_pkg::*;

  localparam int NUM_REGS = 2 ** REG_ADDR_W;

  word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // x0 is hardwired to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* project.f */
hw/rv_isa_pkg.sv
hw/rv_core_pkg.sv
hw/rv_fetch_ctrl.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_lsu.sv
hw/rv_core.sv
verif/rv_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator.
# The run passes only when the pass line shows up in the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f project.f --top-module rv_core_tb -Mdir obj_dir \
  && ./obj_dir/Vrv_core_tb | tee /dev/stderr | grep -qF '*** PASSED ***' \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;
  import rv_isa_pkg::*;

  localparam word_t RESET_PC = '0;
  localparam int MEM_WORDS = 1024;
  localparam int EXP_WORDS = 64;
  localparam int DRAIN_CYCLES = 6;

  logic     clk;
  logic     rst;
  word_t    insn_from_imem;
  word_t    load_data_from_dmem;
  word_t    pc_to_imem;
  word_t    addr_to_dmem;
  word_t    store_data_to_dmem;
  byte_en_t store_we_to_dmem;
  logic     halt;

  word_t mem [MEM_WORDS];
  word_t expect_mem [EXP_WORDS];

  int num_insns;
  int num_stores;
  int cycle_limit;
  int cycles;
  int store_idx;
  int mismatches;
  int failures;

  rv_core #(
    .RESET_PC(RESET_PC)
  ) dut_i (
    .clk                (clk),
    .rst                (rst),
    .insn_from_imem     (insn_from_imem),
    .load_data_from_dmem(load_data_from_dmem),
    .pc_to_imem         (pc_to_imem),
    .addr_to_dmem       (addr_to_dmem),
    .store_data_to_dmem (store_data_to_dmem),
    .store_we_to_dmem   (store_we_to_dmem),
    .halt               (halt)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Registered-read memory shared by fetch and data, read before write
  always @(posedge clk) begin
    insn_from_imem <= mem[pc_to_imem[11:2]];
    load_data_from_dmem <= mem[addr_to_dmem[11:2]];
    for (int b = 0; b < 4; b++) begin
      if (store_we_to_dmem[b]) begin
        mem[addr_to_dmem[11:2]][8*b +: 8] <= store_data_to_dmem[8*b +: 8];
      end
    end
  end

  // Bit mask of the enabled byte lanes
  function automatic word_t lane_mask(byte_en_t en);
    word_t m;
    m = '0;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{en[b]}};
    end
    return m;
  endfunction

  task automatic compare_store();
    int    base;
    word_t mask;
    base = 2 + 3 * store_idx;
    mask = lane_mask(store_we_to_dmem);
    if (store_idx >= num_stores) begin
      failures++;
      $display("Unexpected store at time %0t to address %h", $time, addr_to_dmem);
    end else begin
      if (addr_to_dmem !== expect_mem[base]) begin
        mismatches++;
        $display("Mismatch at time %0t: addr_to_dmem got %h expected %h",
                 $time, addr_to_dmem, expect_mem[base]);
      end
      if ((store_data_to_dmem & mask) !== expect_mem[base+1]) begin
        mismatches++;
        $display("Mismatch at time %0t: store_data_to_dmem got %h expected %h",
                 $time, store_data_to_dmem & mask, expect_mem[base+1]);
      end
      if (word_t'(store_we_to_dmem) !== expect_mem[base+2]) begin
        mismatches++;
        $display("Mismatch at time %0t: store_we_to_dmem got %h expected %h",
                 $time, store_we_to_dmem, expect_mem[base+2][3:0]);
      end
    end
    store_idx++;
  endtask

  always @(posedge clk) begin
    if (!rst && store_we_to_dmem != '0) begin
      compare_store();
    end
  end

  initial begin
    void'($urandom(32'h7ca3));
    rst = 1'b1;
    insn_from_imem = '0;
    load_data_from_dmem = '0;
    store_idx = 0;
    mismatches = 0;
    failures = 0;
    cycles = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = $urandom();
    end
    $readmemh("verif/rv_testdata_prog.hex", mem);
    $readmemh("verif/rv_testdata_expect.hex", expect_mem);
    num_insns = expect_mem[0];
    num_stores = expect_mem[1];
    cycle_limit = 3 * num_insns + 20;

    repeat (8) @(posedge clk);
    // Outputs while held in reset
    if (pc_to_imem !== RESET_PC) begin
      mismatches++;
      $display("Mismatch at time %0t: pc_to_imem got %h expected %h",
               $time, pc_to_imem, RESET_PC);
    end
    if (halt !== 1'b0) begin
      mismatches++;
      $display("Mismatch at time %0t: halt got %b expected %b",
               $time, halt, 1'b0);
    end
    if (store_we_to_dmem !== '0) begin
      mismatches++;
      $display("Mismatch at time %0t: store_we_to_dmem got %h expected %h",
               $time, store_we_to_dmem, 4'h0);
    end
    if (addr_to_dmem !== '0) begin
      mismatches++;
      $display("Mismatch at time %0t: addr_to_dmem got %h expected %h",
               $time, addr_to_dmem, 32'h0);
    end
    rst <= 1'b0;

    while (!halt && cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
      if (store_idx == 0 && halt) begin
        failures++;
        $display("Halt rose before the first store at time %0t", $time);
      end
    end

    if (!halt) begin
      failures++;
      $display("timeout before halt after %0d cycles", cycles);
    end else begin
      // Core must stay halted and quiet
      repeat (DRAIN_CYCLES) begin
        @(posedge clk);
        if (!halt) begin
          failures++;
          $display("Halt dropped at time %0t", $time);
        end
      end
      if (store_idx != num_stores) begin
        failures++;
        $display("Saw %0d stores where %0d were expected", store_idx, num_stores);
      end
    end

    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verif/rv_testdata_expect.hex */
// Executed instruction count, store count,
// then per store: word address, data in enabled lanes, byte enables
0000002E
00000009
00000400
12345678
0000000F
00000404
FFFFFFEC
0000000F
00000408
00000091
0000000F
00000400
00680000
0000000C
00000404
0000FB00
00000002
0000040C
00000063
0000000F
00000410
FFFFFB94
0000000F
00000414
00000000
0000000F
00000414
56780000
0000000C

/* verif/rv_testdata_prog.hex */
// One instruction word per line, loaded from byte address 0
40000093
12345137
67810113
0020A023
FFB00193
4011D213
0041B2B3
0001A333
00431313
0062E2B3
405202B3
0050A223
00000397
00300413
00748493
FFF40413
FE041CE3
007484B3
0080056F
00000493
00040463
00000493
0001E463
00A484B3
0090A423
06C005E7
00000593
00B09123
003082A3
00508603
0020D683
00409703
0000C783
00D60633
00F74733
00C0A623
00E0A823
0000A803
00580013
0000AA23
01009B23
0FF0000F
00000073
